//--- common/sramPkg.sv
package sramPkg;

	localparam int wordW = 32;
	localparam int byteCount = 4;
	localparam int addrMaxW = 11; // Largest supported memory of 2048 words
	localparam int macroAddrW = 9; // One 512x8 macro

	// 1 = write this byte
	typedef logic [byteCount-1:0] byteMaskT;

	// Primary port does reads and masked writes
	typedef struct packed {
		logic write;
		byteMaskT mask;
		logic [addrMaxW-1:0] addr;
		logic [wordW-1:0] data;
	} primReqT;

	typedef struct packed {
		logic [addrMaxW-1:0] addr;
	} secReqT;

	typedef struct packed {
		logic [wordW-1:0] data;
	} primRspT;

	// Address echoed for matching on the consumer side
	typedef struct packed {
		logic [wordW-1:0] data;
		logic [addrMaxW-1:0] addr;
	} secRspT;

endpackage

//--- sramMacro/sramMacroModel.sv
`timescale 1ns/1ns

module sramMacroModel (
	input logic clk,
	input logic rwSelect,
	input logic writeEnable,
	input logic writeByte,
	input logic [sramPkg::macroAddrW-1:0] rwAddr,
	input logic [7:0] writeData,
	input logic rdSelect,
	input logic [sramPkg::macroAddrW-1:0] rdAddr,
	output logic [7:0] rwData,
	output logic [7:0] rdData
);

	localparam int depth = 1 << sramPkg::macroAddrW;

	logic [7:0] mem [depth];
	logic armed; // Set once both selects have been seen idle

	always_ff @(posedge clk) begin
		if (rwSelect) begin
			if (writeEnable && writeByte)
				mem[rwAddr] <= writeData;
			rwData <= mem[rwAddr]; // Old contents on a write
		end
	end

	// Read port sees the old byte when the RW port writes the same edge
	always_ff @(posedge clk) begin
		if (rdSelect)
			rdData <= mem[rdAddr];
	end

	always_ff @(posedge clk) begin
		if (!rwSelect && !rdSelect)
			armed <= 1'b1;
	end

	selectKnown: assert property (@(posedge clk)
		armed |-> !$isunknown({rwSelect, rdSelect}))
		else $error("sramMacroModel: select is unknown");

endmodule

//--- sramMacro/sramArray.sv
`timescale 1ns/1ns

module sramArray #(
	parameter int addrW = 11,
	parameter int bytes = 4
) (
	input logic clk,
	input logic rstN,
	input logic primSelect,
	input logic primWrite,
	input sramPkg::byteMaskT primMask,
	input logic [sramPkg::addrMaxW-1:0] primAddr,
	input logic [8*bytes-1:0] primWriteData,
	input logic secSelect,
	input logic [sramPkg::addrMaxW-1:0] secAddr,
	output logic [8*bytes-1:0] primReadData,
	output logic [8*bytes-1:0] secReadData
);

	// Address bits this level decodes
	localparam logic [sramPkg::addrMaxW-1:0] inRange =
		~({sramPkg::addrMaxW{1'b1}} << addrW);

	generate
		if (bytes == 4) begin : gColumns
			// One column per byte lane
			for (genvar i = 0; i < bytes; i++) begin : gByte
				sramArray #(
					.addrW(addrW),
					.bytes(1)
				) uColumn (
					.clk(clk),
					.rstN(rstN),
					.primSelect(primSelect),
					.primWrite(primWrite),
					.primMask(sramPkg::byteMaskT'(primMask[i])),
					.primAddr(primAddr),
					.primWriteData(primWriteData[i*8 +: 8]),
					.secSelect(secSelect),
					.secAddr(secAddr),
					.primReadData(primReadData[i*8 +: 8]),
					.secReadData(secReadData[i*8 +: 8])
				);
			end
		end else if (bytes == 1 && addrW == sramPkg::macroAddrW) begin : gLeaf
			sramMacroModel uMacro (
				.clk(clk),
				.rwSelect(primSelect),
				.writeEnable(primWrite),
				.writeByte(primMask[0]), // Lane mask lands in bit 0
				.rwAddr(primAddr[sramPkg::macroAddrW-1:0]),
				.writeData(primWriteData),
				.rdSelect(secSelect),
				.rdAddr(secAddr[sramPkg::macroAddrW-1:0]),
				.rwData(primReadData),
				.rdData(secReadData)
			);
		end else if (bytes == 1 && addrW > sramPkg::macroAddrW &&
				addrW <= sramPkg::addrMaxW) begin : gSplit
			localparam logic [sramPkg::addrMaxW-1:0] topBit =
				{{(sramPkg::addrMaxW-1){1'b0}}, 1'b1} << (addrW - 1);

			logic [8*bytes-1:0] primHigh, primLow;
			logic [8*bytes-1:0] secHigh, secLow;
			logic [sramPkg::addrMaxW-1:0] primSubAddr, secSubAddr;
			logic primHighQ, secHighQ; // Half that was read last

			assign primSubAddr = primAddr & ~topBit;
			assign secSubAddr = secAddr & ~topBit;

			sramArray #(
				.addrW(addrW - 1),
				.bytes(1)
			) uHigh (
				.clk(clk),
				.rstN(rstN),
				.primSelect(primSelect && primAddr[addrW-1]),
				.primWrite(primWrite),
				.primMask(primMask),
				.primAddr(primSubAddr),
				.primWriteData(primWriteData),
				.secSelect(secSelect && secAddr[addrW-1]),
				.secAddr(secSubAddr),
				.primReadData(primHigh),
				.secReadData(secHigh)
			);

			sramArray #(
				.addrW(addrW - 1),
				.bytes(1)
			) uLow (
				.clk(clk),
				.rstN(rstN),
				.primSelect(primSelect && !primAddr[addrW-1]),
				.primWrite(primWrite),
				.primMask(primMask),
				.primAddr(primSubAddr),
				.primWriteData(primWriteData),
				.secSelect(secSelect && !secAddr[addrW-1]),
				.secAddr(secSubAddr),
				.primReadData(primLow),
				.secReadData(secLow)
			);

			// Steer by the address sampled with the read, not the live one
			always_ff @(posedge clk) begin
				if (!rstN) begin
					primHighQ <= 1'b0;
					secHighQ <= 1'b0;
				end else begin
					if (primSelect)
						primHighQ <= primAddr[addrW-1];
					if (secSelect)
						secHighQ <= secAddr[addrW-1];
				end
			end

			assign primReadData = primHighQ ? primHigh : primLow;
			assign secReadData = secHighQ ? secHigh : secLow;
		end else begin : gUnsupported
			$error("sramArray: unsupported addrW %0d or bytes %0d", addrW, bytes);
		end
	endgenerate

	addrInRange: assert property (@(posedge clk) disable iff (!rstN)
		(!primSelect || (primAddr & ~inRange) == '0) &&
		(!secSelect || (secAddr & ~inRange) == '0))
		else $error("sramArray: address above bit %0d on a select", addrW - 1);

endmodule

//--- design/sramPortCtrl.sv
`timescale 1ns/1ns

module sramPortCtrl #(
	parameter type rspT = sramPkg::primRspT
) (
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input logic reqIsRead,
	output logic reqReady,
	output logic fire,
	input rspT arrayRsp,
	output logic rspValid,
	input logic rspReady,
	output rspT rsp
);

	logic [1:0] credits; // Free response slots
	logic pendingRead; // Array data due this cycle
	logic [1:0] fifoCount;
	logic wrPtr;
	logic rdPtr;
	logic readFire;
	logic pop;
	rspT fifoMem [2];

	assign reqReady = credits != 2'd0;
	assign fire = reqValid && reqReady;
	assign readFire = fire && reqIsRead; // Writes never take a credit
	assign rspValid = fifoCount != 2'd0;
	assign pop = rspValid && rspReady;
	assign rsp = fifoMem[rdPtr];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			credits <= 2'd2;
			pendingRead <= 1'b0;
			fifoCount <= 2'd0;
			wrPtr <= 1'b0;
			rdPtr <= 1'b0;
		end else begin
			credits <= credits - {1'b0, readFire} + {1'b0, pop};
			pendingRead <= readFire;
			fifoCount <= fifoCount + {1'b0, pendingRead} - {1'b0, pop};
			if (pendingRead)
				wrPtr <= ~wrPtr;
			if (pop)
				rdPtr <= ~rdPtr;
		end
	end

	// Capture one cycle after the read fired
	always_ff @(posedge clk) begin
		if (pendingRead)
			fifoMem[wrPtr] <= arrayRsp;
	end

	// Credits must keep the FIFO from filling past two entries
	noOverflow: assert property (@(posedge clk) disable iff (!rstN)
		pendingRead && !pop |-> fifoCount < 2'd2)
		else $error("sramPortCtrl: response FIFO overflow");

	rspHeld: assert property (@(posedge clk) disable iff (!rstN)
		rspValid && !rspReady |=> rspValid && $stable(rsp))
		else $error("sramPortCtrl: response changed while stalled");

endmodule

//--- design/sramSubsystem.sv
`timescale 1ns/1ns

module sramSubsystem #(
	parameter int memAddrW = 11
) (
	input logic clk,
	input logic rstN,

	input logic primReqValid,
	output logic primReqReady,
	input sramPkg::primReqT primReq,
	output logic primRspValid,
	input logic primRspReady,
	output sramPkg::primRspT primRsp,

	input logic secReqValid,
	output logic secReqReady,
	input sramPkg::secReqT secReq,
	output logic secRspValid,
	input logic secRspReady,
	output sramPkg::secRspT secRsp
);

	logic primFire;
	logic secFire;
	logic [sramPkg::wordW-1:0] primReadData;
	logic [sramPkg::wordW-1:0] secReadData;
	logic [sramPkg::addrMaxW-1:0] secAddrQ; // Address of the read in flight
	sramPkg::primRspT primArrayRsp;
	sramPkg::secRspT secArrayRsp;

	always_ff @(posedge clk) begin
		if (secFire)
			secAddrQ <= secReq.addr;
	end

	assign primArrayRsp = '{data: primReadData};
	assign secArrayRsp = '{data: secReadData, addr: secAddrQ};

	sramPortCtrl #(
		.rspT(sramPkg::primRspT)
	) uPrimCtrl (
		.clk(clk),
		.rstN(rstN),
		.reqValid(primReqValid),
		.reqIsRead(!primReq.write),
		.reqReady(primReqReady),
		.fire(primFire),
		.arrayRsp(primArrayRsp),
		.rspValid(primRspValid),
		.rspReady(primRspReady),
		.rsp(primRsp)
	);

	sramPortCtrl #(
		.rspT(sramPkg::secRspT)
	) uSecCtrl (
		.clk(clk),
		.rstN(rstN),
		.reqValid(secReqValid),
		.reqIsRead(1'b1), // Read-only port
		.reqReady(secReqReady),
		.fire(secFire),
		.arrayRsp(secArrayRsp),
		.rspValid(secRspValid),
		.rspReady(secRspReady),
		.rsp(secRsp)
	);

	sramArray #(
		.addrW(memAddrW),
		.bytes(sramPkg::byteCount)
	) uArray (
		.clk(clk),
		.rstN(rstN),
		.primSelect(primFire),
		.primWrite(primReq.write),
		.primMask(primReq.mask),
		.primAddr(primReq.addr),
		.primWriteData(primReq.data),
		.secSelect(secFire),
		.secAddr(secReq.addr),
		.primReadData(primReadData),
		.secReadData(secReadData)
	);

endmodule

//--- sim/sramSubsystemTb.sv
`timescale 1ns/1ns

module sramSubsystemTb;

	typedef struct packed {
		logic sec;
		logic write;
		logic stall; // Hold this port's response ready low
		logic hasExp;
		logic joinNext; // Issue on the same edge as the next row
		sramPkg::byteMaskT mask;
		logic [sramPkg::addrMaxW-1:0] addr;
		logic [sramPkg::wordW-1:0] data;
		logic [sramPkg::wordW-1:0] expData;
	} rowT;

	typedef struct packed {
		logic [sramPkg::addrMaxW-1:0] addr;
		logic [sramPkg::wordW-1:0] data;
	} expT;

	logic clk = 1'b0;
	logic rstN;
	logic primReqValid;
	logic primReqReady;
	sramPkg::primReqT primReq;
	logic primRspValid;
	logic primRspReady;
	sramPkg::primRspT primRsp;
	logic secReqValid;
	logic secReqReady;
	sramPkg::secReqT secReq;
	logic secRspValid;
	logic secRspReady;
	sramPkg::secRspT secRsp;

	rowT steps[$];
	expT primQ[$];
	expT secQ[$];
	logic [sramPkg::wordW-1:0] refMem [1 << sramPkg::addrMaxW];
	logic [31:0] lfsrState = 32'hfb26bedb;
	logic primStall;
	logic secStall;
	bit stepsBuilt;

	sramSubsystem #(
		.memAddrW(11)
	) u_sramSubsystem (
		.clk(clk),
		.rstN(rstN),
		.primReqValid(primReqValid),
		.primReqReady(primReqReady),
		.primReq(primReq),
		.primRspValid(primRspValid),
		.primRspReady(primRspReady),
		.primRsp(primRsp),
		.secReqValid(secReqValid),
		.secReqReady(secReqReady),
		.secReq(secReq),
		.secRspValid(secRspValid),
		.secRspReady(secRspReady),
		.secRsp(secRsp)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		primRspReady <= !primStall;
		secRspReady <= !secStall;
	end

	task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			$display("Done: errors found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// Galois form stepped once per bit taken
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsrState[0])
				lfsrState = (lfsrState >> 1) ^ 32'h80200003;
			else
				lfsrState = lfsrState >> 1;
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	function automatic logic [31:0] mergeWord(input logic [31:0] old, input logic [31:0] data,
			input sramPkg::byteMaskT mask);
		logic [31:0] word;
		word = old;
		for (int b = 0; b < 4; b++) begin
			if (mask[b])
				word[b*8 +: 8] = data[b*8 +: 8];
		end
		return word;
	endfunction

	// 32 words spread over all four quarters of the memory
	function automatic logic [sramPkg::addrMaxW-1:0] windowAddr(input logic [4:0] sel);
		return {sel[4:3], 6'b010110, sel[2:0]};
	endfunction

	task automatic addRow(input logic sec, input logic write, input sramPkg::byteMaskT mask,
			input logic [sramPkg::addrMaxW-1:0] addr, input logic [31:0] data,
			input logic stall, input logic hasExp, input logic [31:0] expData,
			input logic joinNext);
		rowT r;
		r = '{sec: sec, write: write, stall: stall, hasExp: hasExp, joinNext: joinNext,
			mask: mask, addr: addr, data: data, expData: expData};
		steps.push_back(r);
	endtask

	task automatic addWrite(input logic [sramPkg::addrMaxW-1:0] addr,
			input sramPkg::byteMaskT mask, input logic [31:0] data, input logic joinNext);
		addRow(1'b0, 1'b1, mask, addr, data, 1'b0, 1'b0, '0, joinNext);
	endtask

	task automatic addRead(input logic sec, input logic [sramPkg::addrMaxW-1:0] addr,
			input logic stall, input logic [31:0] expData);
		addRow(sec, 1'b0, '0, addr, '0, stall, 1'b1, expData, 1'b0);
	endtask

	task automatic buildSteps();
		logic isSec;
		logic isWrite;
		sramPkg::byteMaskT mask;
		logic [4:0] sel;
		logic [31:0] data;
		logic [2:0] stallDraw;
		logic [1:0] joinDraw;
		logic [sramPkg::addrMaxW-1:0] addr;
		// Masked merge, then both ports read it back
		addWrite(11'h005, 4'hf, 32'h11223344, 1'b0);
		addWrite(11'h005, 4'b0101, 32'haabbccdd, 1'b0);
		addRead(1'b0, 11'h005, 1'b0, 32'h11bb33dd);
		addRead(1'b1, 11'h005, 1'b0, 32'h11bb33dd);
		addWrite(11'h3a0, 4'hf, 32'hcafe0001, 1'b0);
		addRead(1'b1, 11'h3a0, 1'b0, 32'hcafe0001);
		// Third stalled read has to wait for a credit
		addWrite(11'h010, 4'hf, 32'h01020304, 1'b0);
		addWrite(11'h011, 4'hf, 32'h05060708, 1'b0);
		addWrite(11'h012, 4'hf, 32'h090a0b0c, 1'b0);
		addRead(1'b0, 11'h010, 1'b1, 32'h01020304);
		addRead(1'b0, 11'h011, 1'b1, 32'h05060708);
		addRead(1'b0, 11'h012, 1'b1, 32'h090a0b0c);
		addRead(1'b0, 11'h010, 1'b0, 32'h01020304);
		for (int q = 0; q < 4; q++) begin
			addr = {2'(q), 9'h055};
			addWrite(addr, 4'hf, 32'h0a0b0c0d + 32'(q) * 32'h10101010, 1'b0);
		end
		for (int q = 0; q < 4; q++) begin
			addr = {2'(q), 9'h055};
			addRead(1'b0, addr, 1'b0, 32'h0a0b0c0d + 32'(q) * 32'h10101010);
			addRead(1'b1, addr, 1'b0, 32'h0a0b0c0d + 32'(q) * 32'h10101010);
		end
		// Same-edge collision gives old data on the secondary port
		addWrite(11'h123, 4'hf, 32'h01010101, 1'b0);
		addWrite(11'h123, 4'hf, 32'h02020202, 1'b1);
		addRead(1'b1, 11'h123, 1'b0, 32'h01010101);
		addRead(1'b1, 11'h123, 1'b0, 32'h02020202);
		addRead(1'b0, 11'h123, 1'b0, 32'h02020202);
		for (int n = 0; n < 32; n++)
			addWrite(windowAddr(5'(n)), 4'hf, takeBits(32), 1'b0);
		for (int n = 0; n < 64; n++) begin
			isSec = 1'(takeBits(1));
			isWrite = 1'(takeBits(1));
			mask = 4'(takeBits(4));
			sel = 5'(takeBits(5));
			data = takeBits(32);
			stallDraw = 3'(takeBits(3));
			joinDraw = 2'(takeBits(2));
			if (isSec) begin
				addRow(1'b1, 1'b0, '0, windowAddr(sel), '0, stallDraw == 0, 1'b0, '0, 1'b0);
			end else begin
				addRow(1'b0, isWrite, mask, windowAddr(sel), data, stallDraw == 0, 1'b0, '0,
					joinDraw == 0);
				if (joinDraw == 0)
					addRow(1'b1, 1'b0, '0, windowAddr(sel), '0, 1'b0, 1'b0, '0, 1'b0);
			end
		end
	endtask

	task automatic recordTransfer(input int first, input int count);
		rowT r;
		expT e;
		// Reads see the memory as it was before this edge
		for (int k = first; k < first + count; k++) begin
			r = steps[k];
			if (!r.write) begin
				e.addr = r.addr;
				e.data = r.hasExp ? r.expData : refMem[r.addr];
				if (r.sec)
					secQ.push_back(e);
				else
					primQ.push_back(e);
			end
		end
		for (int k = first; k < first + count; k++) begin
			r = steps[k];
			if (r.write)
				refMem[r.addr] = mergeWord(refMem[r.addr], r.data, r.mask);
		end
	endtask

	task automatic issueGroup(input int first, input int count);
		logic needPrim;
		logic needSec;
		rowT r;
		needPrim = 1'b0;
		needSec = 1'b0;
		@(negedge clk);
		for (int k = first; k < first + count; k++) begin
			r = steps[k];
			if (r.sec) begin
				needSec = 1'b1;
				secStall = r.stall;
			end else begin
				needPrim = 1'b1;
				primStall = r.stall;
			end
		end
		// A stalled consumer that blocks the port gets released
		while ((needPrim && !primReqReady) || (needSec && !secReqReady)) begin
			if (needPrim && !primReqReady)
				primStall = 1'b0;
			if (needSec && !secReqReady)
				secStall = 1'b0;
			@(negedge clk);
		end
		@(posedge clk);
		for (int k = first; k < first + count; k++) begin
			r = steps[k];
			if (r.sec) begin
				secReqValid <= 1'b1;
				secReq <= '{addr: r.addr};
			end else begin
				primReqValid <= 1'b1;
				primReq <= '{write: r.write, mask: r.mask, addr: r.addr, data: r.data};
			end
		end
		@(negedge clk);
		while ((needPrim && !primReqReady) || (needSec && !secReqReady))
			@(negedge clk);
		@(posedge clk);
		recordTransfer(first, count);
		primReqValid <= 1'b0;
		secReqValid <= 1'b0;
	endtask

	always @(negedge clk) begin : respMonitor
		expT e;
		if (rstN) begin
			// Ready follows the reads still owed to each port
			checkValue(64'(primReqReady), 64'(primQ.size() < 2), "primary request ready");
			checkValue(64'(secReqReady), 64'(secQ.size() < 2), "secondary request ready");
			if (primRspValid && primRspReady) begin
				checkValue(64'(primQ.size() != 0), 64'(1), "primary response not expected");
				e = primQ.pop_front();
				checkValue(64'(primRsp.data), 64'(e.data), "primary read data");
			end
			if (secRspValid && secRspReady) begin
				checkValue(64'(secQ.size() != 0), 64'(1), "secondary response not expected");
				e = secQ.pop_front();
				checkValue(64'(secRsp.data), 64'(e.data), "secondary read data");
				checkValue(64'(secRsp.addr), 64'(e.addr), "secondary echoed address");
			end
		end
	end

	initial begin : watchdog
		wait (stepsBuilt);
		repeat (steps.size() * 40 + 200) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", steps.size() * 40 + 200);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin : mainSequence
		int i;
		int count;
		rstN <= 1'b0;
		primReqValid <= 1'b0;
		primReq <= '0;
		primRspReady <= 1'b1;
		secReqValid <= 1'b0;
		secReq <= '0;
		secRspReady <= 1'b1;
		primStall = 1'b0;
		secStall = 1'b0;
		buildSteps();
		stepsBuilt = 1'b1;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkValue(64'(primRspValid), 64'(0), "primary response valid after reset");
		checkValue(64'(secRspValid), 64'(0), "secondary response valid after reset");
		i = 0;
		while (i < steps.size()) begin
			count = steps[i].joinNext ? 2 : 1;
			issueGroup(i, count);
			i += count;
		end
		@(negedge clk);
		primStall = 1'b0;
		secStall = 1'b0;
		while (primQ.size() != 0 || secQ.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		checkValue(64'(primRspValid), 64'(0), "primary response left over");
		checkValue(64'(secRspValid), 64'(0), "secondary response left over");
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- sramBank.f
common/sramPkg.sv
sramMacro/sramMacroModel.sv
sramMacro/sramArray.sv
design/sramPortCtrl.sv
design/sramSubsystem.sv
sim/sramSubsystemTb.sv

//--- Makefile
# Verilator build and run for the sramBank project

VERILATOR ?= verilator
TOP ?= sramSubsystemTb
FILELIST ?= sramBank.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIMBIN := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIMBIN)

$(SIMBIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_TEXT)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR)
